//--- pat_settings.svh
`ifndef PAT_SETTINGS_SVH
`define PAT_SETTINGS_SVH

// datapath and instruction word
`define PAT_DATA_W 8
`define PAT_INSTR_W 20
`define PAT_IADDR_W 10 // 1k instruction space

// storage sizes
`define PAT_DMEM_DEPTH 256
`define PAT_CALL_DEPTH 8 // max nesting of call
`define PAT_NUM_OUTS 8

// first fetch address after reset
`define PAT_RESET_PC 0

`endif

//--- pat_pkg.sv
`include "pat_settings.svh"

package pat_pkg;

	typedef logic [`PAT_DATA_W-1:0] word_t;
	typedef logic [`PAT_IADDR_W-1:0] iaddr_t;
	typedef logic [`PAT_INSTR_W-1:0] instr_t;

	// i8 opcodes in bits 11..8
	typedef enum logic [3:0] {
		i8_or = 4'd0,
		i8_and = 4'd1,
		i8_addm = 4'd2,
		i8_subm = 4'd3,
		i8_add = 4'd4,
		i8_sub = 4'd5,
		i8_ldi = 4'd6,
		i8_ldm = 4'd7,
		i8_bf = 4'd8,
		i8_bb = 4'd9,
		i8_call = 4'd10,
		i8_stam = 4'd11,
		i8_setsp = 4'd12, // decoded as nop
		i8_orm = 4'd13,
		i8_andm = 4'd14,
		i8_prefix = 4'd15 // escape into i3 space
	} op_i8_e;

	// i3 opcodes in bits 7..4
	typedef enum logic [3:0] {
		i3_shl = 4'd0,
		i3_shlo = 4'd1,
		i3_shr = 4'd2,
		i3_asr = 4'd3,
		i3_out = 4'd8,
		i3_prefix = 4'd15 // escape into i0 space
	} op_i3_e;

	// i0 opcodes in bits 3..0
	typedef enum logic [3:0] {
		i0_not = 4'd0,
		i0_ret = 4'd3,
		i0_nop = 4'd5
	} op_i0_e;

	typedef enum logic [3:0] {
		alu_or, alu_and, alu_not, alu_add, alu_sub,
		alu_shl, alu_shlo, alu_shr, alu_asr, alu_pass_b
	} alu_op_e;

	// predicate on the flags in bits 14..13
	typedef enum logic [1:0] {
		cond_z = 2'b00,
		cond_n = 2'b01,
		cond_al = 2'b10,
		cond_always = 2'b11
	} cond_e;

	typedef enum logic [2:0] {
		ctl_none, ctl_bf, ctl_bb, ctl_call, ctl_ret
	} ctl_e;

endpackage

//--- pat_decode_if.sv
`timescale 1ns/1ps

// decode register contents as seen by the execute stage
interface pat_decode_if
	import pat_pkg::*;
();
	logic valid;
	iaddr_t pc;
	alu_op_e alu_op;
	logic use_mem; // operand b from data memory
	logic wr_acc;
	logic wr_mem;
	logic do_out;
	ctl_e ctl;
	cond_e cond;
	word_t imm; // i3 immediate already zero extended

	modport producer (
		output valid, pc, alu_op, use_mem, wr_acc, wr_mem, do_out, ctl, cond, imm
	);

	modport consumer (
		input valid, pc, alu_op, use_mem, wr_acc, wr_mem, do_out, ctl, cond, imm
	);
endinterface

//--- pat_alu.sv
`timescale 1ns/1ps

module pat_alu
	import pat_pkg::*;
(
	input alu_op_e i_op,
	input word_t i_a, // accumulator
	input word_t i_b,
	output word_t o_y
);

	logic sub;
	word_t b_in;
	word_t sum;
	logic [2:0] sh; // shift distance

	// one adder for add and sub with ~b plus carry in
	assign sub = (i_op == alu_sub);
	assign b_in = sub ? ~i_b : i_b;
	assign sum = i_a + b_in + word_t'(sub);
	assign sh = i_b[2:0];

	always_comb
	begin
		case (i_op)
			alu_or: o_y = i_a | i_b;
			alu_and: o_y = i_a & i_b;
			alu_not: o_y = ~i_a;
			alu_add, alu_sub: o_y = sum;
			alu_shl: o_y = i_a << sh;
			alu_shlo: o_y = ~((~i_a) << sh); // ones shifted in from the right
			alu_shr: o_y = i_a >> sh;
			alu_asr: o_y = $signed(i_a) >>> sh;
			default: o_y = i_b; // pass_b for ldi and ldm
		endcase
	end

endmodule

//--- pat_data_mem.sv
`timescale 1ns/1ps

module pat_data_mem
	import pat_pkg::*;
#(
	parameter int DEPTH = 256
)
(
	input logic clk,
	input logic [$clog2(DEPTH)-1:0] i_rd_addr,
	input logic [$clog2(DEPTH)-1:0] i_wr_addr,
	input logic i_wr_en,
	input word_t i_wr_data,
	output word_t o_rd_data
);

	word_t mem [DEPTH];

	assign o_rd_data = mem[i_rd_addr]; // read within the same cycle

	always_ff @(posedge clk)
	begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

endmodule

//--- pat_call_stack.sv
`timescale 1ns/1ps

module pat_call_stack
	import pat_pkg::*;
#(
	parameter int DEPTH = 8
)
(
	input logic clk,
	input logic reset,
	input logic i_push,
	input logic i_pop,
	input iaddr_t i_push_addr,
	output iaddr_t o_top
);

	iaddr_t stack [DEPTH];
	logic [$clog2(DEPTH)-1:0] ptr; // next free slot that wraps on overflow

	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (i_push)
			ptr <= ptr + 1'b1;
		else if (i_pop)
			ptr <= ptr - 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (i_push)
			stack[ptr] <= i_push_addr;
	end

	assign o_top = stack[ptr - 1'b1]; // most recent return address

endmodule

//--- pat_fetch.sv
`timescale 1ns/1ps
`include "pat_settings.svh"

module pat_fetch
	import pat_pkg::*;
(
	input logic clk,
	input logic reset,
	input instr_t i_instr,
	input logic i_redirect,
	input iaddr_t i_target,
	output iaddr_t o_pc,
	output instr_t o_ir,
	output iaddr_t o_ir_pc,
	output logic o_ir_valid
);

	// address whose word arrives on i_instr this cycle
	iaddr_t req_pc;
	logic req_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_pc <= iaddr_t'(`PAT_RESET_PC);
			req_valid <= 1'b0;
			o_ir_valid <= 1'b0;
		end
		else if (i_redirect)
		begin
			o_pc <= i_target;
			req_valid <= 1'b0; // word for the old path is dropped
			o_ir_valid <= 1'b0;
		end
		else
		begin
			o_pc <= o_pc + iaddr_t'(1);
			req_valid <= 1'b1;
			o_ir_valid <= req_valid;
		end
	end

	// payload travels alongside the valid bits
	always_ff @(posedge clk)
	begin
		req_pc <= o_pc;
		o_ir <= i_instr;
		o_ir_pc <= req_pc;
	end

endmodule

//--- pat_decoder.sv
`timescale 1ns/1ps

module pat_decoder
	import pat_pkg::*;
(
	input logic clk,
	input logic reset,
	input instr_t i_ir,
	input iaddr_t i_ir_pc,
	input logic i_ir_valid,
	input logic i_squash,
	pat_decode_if.producer dec
);

	op_i8_e op8;
	op_i3_e op3;
	op_i0_e op0;
	logic is_i8;
	logic is_i3;
	alu_op_e alu_op;
	logic use_mem;
	logic wr_acc;
	logic wr_mem;
	logic do_out;
	ctl_e ctl;

	assign op8 = op_i8_e'(i_ir[11:8]);
	assign op3 = op_i3_e'(i_ir[7:4]);
	assign op0 = op_i0_e'(i_ir[3:0]);
	assign is_i8 = (op8 != i8_prefix);
	assign is_i3 = !is_i8 && (op3 != i3_prefix); // both prefixes mean i0

	always_comb
	begin
		alu_op = alu_pass_b;
		use_mem = 1'b0;
		wr_acc = 1'b0;
		wr_mem = 1'b0;
		do_out = 1'b0;
		ctl = ctl_none;
		if (is_i8)
		begin
			case (op8)
				i8_or, i8_orm: alu_op = alu_or;
				i8_and, i8_andm: alu_op = alu_and;
				i8_add, i8_addm: alu_op = alu_add;
				i8_sub, i8_subm: alu_op = alu_sub;
				default: alu_op = alu_pass_b; // ldi and ldm
			endcase
			use_mem = op8 inside {i8_ldm, i8_addm, i8_subm, i8_orm, i8_andm};
			wr_acc = op8 inside {i8_or, i8_and, i8_add, i8_sub, i8_ldi,
				i8_ldm, i8_addm, i8_subm, i8_orm, i8_andm};
			wr_mem = (op8 == i8_stam);
			case (op8)
				i8_bf: ctl = ctl_bf;
				i8_bb: ctl = ctl_bb;
				i8_call: ctl = ctl_call;
				default: ctl = ctl_none;
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				i3_shl: alu_op = alu_shl;
				i3_shlo: alu_op = alu_shlo;
				i3_shr: alu_op = alu_shr;
				default: alu_op = alu_asr;
			endcase
			wr_acc = op3 inside {i3_shl, i3_shlo, i3_shr, i3_asr};
			do_out = (op3 == i3_out);
		end
		else
		begin
			// i0 space where nop and unknown codes fall through
			alu_op = alu_not;
			wr_acc = (op0 == i0_not);
			ctl = (op0 == i0_ret) ? ctl_ret : ctl_none;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset || i_squash)
			dec.valid <= 1'b0;
		else
			dec.valid <= i_ir_valid;
	end

	always_ff @(posedge clk)
	begin
		dec.pc <= i_ir_pc;
		dec.alu_op <= alu_op;
		dec.use_mem <= use_mem;
		dec.wr_acc <= wr_acc;
		dec.wr_mem <= wr_mem;
		dec.do_out <= do_out;
		dec.ctl <= ctl;
		dec.cond <= cond_e'(i_ir[14:13]);
		dec.imm <= is_i8 ? i_ir[7:0] : word_t'(i_ir[2:0]);
	end

endmodule

//--- pat_exec.sv
`timescale 1ns/1ps
`include "pat_settings.svh"

module pat_exec
	import pat_pkg::*;
(
	input logic clk,
	input logic reset,
	pat_decode_if.consumer dec,
	output logic o_redirect,
	output iaddr_t o_target,
	output logic o_out_valid,
	output logic [$clog2(`PAT_NUM_OUTS)-1:0] o_out_sel,
	output word_t o_out_data
);

	localparam int SEL_W = $clog2(`PAT_NUM_OUTS);

	word_t acc;
	logic z;
	logic n;
	logic cond_ok;
	logic fire; // valid and predicate true
	word_t opb;
	word_t alu_y;
	word_t mem_rd;
	iaddr_t ret_addr;
	iaddr_t ret_top;

	always_comb
	begin
		case (dec.cond)
			cond_z: cond_ok = z;
			cond_n: cond_ok = n;
			default: cond_ok = 1'b1;
		endcase
	end

	assign fire = dec.valid && cond_ok;
	assign opb = dec.use_mem ? mem_rd : dec.imm;
	assign ret_addr = dec.pc + iaddr_t'(1);

	always_comb
	begin
		case (dec.ctl)
			ctl_bf: o_target = dec.pc
				+ {{(`PAT_IADDR_W-`PAT_DATA_W){dec.imm[`PAT_DATA_W-1]}}, dec.imm};
			ctl_bb: o_target = dec.pc - iaddr_t'(dec.imm);
			ctl_call: o_target = iaddr_t'(dec.imm);
			ctl_ret: o_target = ret_top;
			default: o_target = ret_addr;
		endcase
	end

	assign o_redirect = fire && (dec.ctl != ctl_none);

	pat_alu alu_i (
		.i_op (dec.alu_op),
		.i_a (acc),
		.i_b (opb),
		.o_y (alu_y)
	);

	// load and store both address the word at the immediate
	pat_data_mem #(.DEPTH(`PAT_DMEM_DEPTH)) dmem_i (
		.clk (clk),
		.i_rd_addr (dec.imm),
		.i_wr_addr (dec.imm),
		.i_wr_en (fire && dec.wr_mem),
		.i_wr_data (acc),
		.o_rd_data (mem_rd)
	);

	pat_call_stack #(.DEPTH(`PAT_CALL_DEPTH)) cstack_i (
		.clk (clk),
		.reset (reset),
		.i_push (fire && (dec.ctl == ctl_call)),
		.i_pop (fire && (dec.ctl == ctl_ret)),
		.i_push_addr (ret_addr),
		.o_top (ret_top)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			z <= 1'b0;
			n <= 1'b0;
			o_out_valid <= 1'b0;
			o_out_sel <= '0;
			o_out_data <= '0;
		end
		else
		begin
			if (fire && dec.wr_acc)
			begin
				acc <= alu_y;
				z <= (alu_y == '0);
				n <= alu_y[`PAT_DATA_W-1];
			end
			o_out_valid <= fire && dec.do_out; // single cycle strobe
			if (fire && dec.do_out)
			begin
				o_out_sel <= dec.imm[SEL_W-1:0];
				o_out_data <= acc;
			end
		end
	end

endmodule

//--- pat_top.sv
`timescale 1ns/1ps
`include "pat_settings.svh"

module pat_top
	import pat_pkg::*;
(
	input logic clk,
	input logic reset,
	input instr_t i_instr, // word at last cycle's o_pc
	output iaddr_t o_pc,
	output logic o_out_valid,
	output logic [$clog2(`PAT_NUM_OUTS)-1:0] o_out_sel,
	output word_t o_out_data
);

	instr_t ir;
	iaddr_t ir_pc;
	logic ir_valid;
	logic redirect; // also squashes the younger stages
	iaddr_t target;

	pat_decode_if dec_if ();

	pat_fetch fetch_i (
		.clk (clk),
		.reset (reset),
		.i_instr (i_instr),
		.i_redirect (redirect),
		.i_target (target),
		.o_pc (o_pc),
		.o_ir (ir),
		.o_ir_pc (ir_pc),
		.o_ir_valid (ir_valid)
	);

	pat_decoder decoder_i (
		.clk (clk),
		.reset (reset),
		.i_ir (ir),
		.i_ir_pc (ir_pc),
		.i_ir_valid (ir_valid),
		.i_squash (redirect),
		.dec (dec_if.producer)
	);

	pat_exec exec_i (
		.clk (clk),
		.reset (reset),
		.dec (dec_if.consumer),
		.o_redirect (redirect),
		.o_target (target),
		.o_out_valid (o_out_valid),
		.o_out_sel (o_out_sel),
		.o_out_data (o_out_data)
	);

endmodule

//--- pat_props.sv
`timescale 1ns/1ps
`include "pat_settings.svh"

module pat_props
	import pat_pkg::*;
(
	input logic clk,
	input logic reset,
	input iaddr_t o_pc,
	input logic o_out_valid,
	input logic [$clog2(`PAT_NUM_OUTS)-1:0] o_out_sel,
	input word_t o_out_data
);

	int fail_count = 0; // number of failed properties

	// every output is driven once reset is over
	assert property (@(posedge clk) disable iff (reset)
		!$isunknown({o_pc, o_out_valid, o_out_sel, o_out_data}))
	else
	begin
		$error("unknown value on a pat_top output");
		fail_count++;
	end

	assert property (@(posedge clk) $fell(reset) |-> (o_pc == '0))
	else
	begin
		$error("o_pc not at reset address in the first cycle after reset");
		fail_count++;
	end

	// strobe is cleared by the reset edge
	assert property (@(posedge clk) reset |=> !o_out_valid)
	else
	begin
		$error("o_out_valid high while reset is asserted");
		fail_count++;
	end

endmodule

bind pat_top pat_props props_i (
	.clk (clk),
	.reset (reset),
	.o_pc (o_pc),
	.o_out_valid (o_out_valid),
	.o_out_sel (o_out_sel),
	.o_out_data (o_out_data)
);

//--- tb_pat.sv
`timescale 1ns/1ps
`include "pat_settings.svh"

module tb_pat
	import pat_pkg::*;
();

	localparam instr_t NOP_WORD = 20'h04FF5;
	localparam int STROBE_TIMEOUT = 100; // cycles allowed between two strobes
	localparam int QUIET_CYCLES = 50;

	logic clk;
	logic reset;
	instr_t i_instr;
	iaddr_t o_pc;
	logic o_out_valid;
	logic [2:0] o_out_sel;
	word_t o_out_data;

	instr_t prog [1 << `PAT_IADDR_W];
	logic [2:0] exp_sel [$];
	word_t exp_data [$];
	int errors;
	int prop_errors;
	int checks;
	bit seen;
	bit timed_out;

	pat_top pat_top_i (
		.clk (clk),
		.reset (reset),
		.i_instr (i_instr),
		.o_pc (o_pc),
		.o_out_valid (o_out_valid),
		.o_out_sel (o_out_sel),
		.o_out_data (o_out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// synchronous ROM model returning the word at last cycle's o_pc
	always @(posedge clk)
	begin
		if ($isunknown(o_pc))
			i_instr <= NOP_WORD;
		else
			i_instr <= prog[o_pc];
	end

	task automatic load_testdata();
		integer fd;
		integer code;
		logic [7:0] tag;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [8*160-1:0] rest;
		for (int a = 0; a < (1 << `PAT_IADDR_W); a++)
			prog[a] = NOP_WORD; // unloaded addresses
		fd = $fopen("pat_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open pat_testdata.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fscanf(fd, " %c", tag);
				if (code != 1)
					break;
				if (tag == "#")
					code = $fgets(rest, fd); // rest of a comment
				else
				begin
					code = $fscanf(fd, "%h %h", f1, f2);
					if (code != 2)
					begin
						$display("malformed record in pat_testdata.txt");
						errors++;
					end
					else if (tag == "p")
						prog[f1[`PAT_IADDR_W-1:0]] = f2[`PAT_INSTR_W-1:0];
					else if (tag == "e")
					begin
						exp_sel.push_back(f1[2:0]);
						exp_data.push_back(f2[`PAT_DATA_W-1:0]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// polls o_out_valid on falling edges
	task automatic wait_strobe(output bit found);
		int cycles;
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < STROBE_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
			if (o_out_valid === 1'b1)
				found = 1'b1;
		end
	endtask

	initial
	begin
		errors = 0;
		prop_errors = 0;
		checks = 0;
		timed_out = 1'b0;
		reset = 1'b1;
		i_instr = NOP_WORD;
		load_testdata();
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checks++;
		assert (o_pc === iaddr_t'(0))
		else
		begin
			$display("CHECK FAILED o_pc: got %h expected %h", o_pc, iaddr_t'(0));
			errors++;
		end

		for (int i = 0; i < exp_sel.size(); i++)
		begin
			wait_strobe(seen);
			if (!seen)
			begin
				$display("timeout: output strobe %0d of %0d never appeared",
					i, exp_sel.size());
				errors++;
				timed_out = 1'b1;
				break;
			end
			checks += 2;
			assert (o_out_sel === exp_sel[i])
			else
			begin
				$display("CHECK FAILED o_out_sel: strobe %0d got %h expected %h",
					i, o_out_sel, exp_sel[i]);
				errors++;
			end
			assert (o_out_data === exp_data[i])
			else
			begin
				$display("CHECK FAILED o_out_data: strobe %0d got %h expected %h",
					i, o_out_data, exp_data[i]);
				errors++;
			end
		end

		// program now spins on bf 0 and may emit nothing more
		if (!timed_out)
		begin
			for (int c = 0; c < QUIET_CYCLES; c++)
			begin
				@(negedge clk);
				checks++;
				assert (o_out_valid !== 1'b1)
				else
				begin
					$display("extra output strobe after the last expected one, sel %h data %h",
						o_out_sel, o_out_data);
					errors++;
				end
			end
		end

		prop_errors = pat_top_i.props_i.fail_count;
		$display("tb_pat: %0d strobes expected, %0d checks, %0d errors, %0d property failures",
			exp_sel.size(), checks, errors, prop_errors);
		if (errors == 0 && prop_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- tb.f
+incdir+.
pat_pkg.sv
pat_decode_if.sv
pat_alu.sv
pat_data_mem.sv
pat_call_stack.sv
pat_fetch.sv
pat_decoder.sv
pat_exec.sv
pat_top.sv
pat_props.sv
tb_pat.sv

//--- pat_testdata.txt
# p <addr> <instruction word>   program word, all hex
# e <sel> <data>                expected out strobe in order, all hex
p 00 0465A  # ldi 5a
p 01 04F80  # out 0
p 02 04433  # add 33
p 03 04F81
p 04 0450F  # sub 0f
p 05 04081  # or 81
p 06 0413C  # and 3c
p 07 04F82
p 08 04FF0  # not
p 09 04F83
p 0A 04F02  # shl 2
p 0B 04F84
p 0C 04F13  # shlo 3
p 0D 04F85
p 0E 04696
p 0F 04F21  # shr 1
p 10 04F86
p 11 04696
p 12 04F32  # asr 2
p 13 04F87
p 14 04621
p 15 04B10  # stam 10
p 16 0460C
p 17 04B20  # stam 20
p 18 04710  # ldm 10
p 19 04F80
p 1A 04210  # addm 10
p 1B 04320  # subm 20
p 1C 04F81
p 1D 04D20  # orm 20
p 1E 04E10  # andm 10
p 1F 04F82
p 20 04520  # sub 20 gives zero
p 21 00803  # bf if z +3, taken
p 22 04F80  # squashed
p 23 04F81  # squashed
p 24 02803  # bf if n, not taken
p 25 04F83
p 26 04501  # sub 1 gives ff
p 27 00802  # bf if z, not taken
p 28 04F84
p 29 02803  # bf if n +3, taken
p 2A 04F85
p 2B 04F85
p 2C 04F86
p 2D 04603  # loop count 3
p 2E 04F87
p 2F 04501
p 30 00802  # exit when zero
p 31 04903  # bb 3 back to 2e
p 32 02910  # bb if n, not taken
p 33 04F80
p 34 04A40  # call 40
p 35 04F82
p 36 04800  # bf 0, spin here
p 40 04611
p 41 04F80
p 42 04A50  # nested call 50
p 43 04F81
p 44 04FF3  # ret
p 50 04422
p 51 04F83
p 52 04FF3
e 0 5A
e 1 8D
e 2 3C
e 3 C3
e 4 0C
e 5 67
e 6 4B
e 7 E5
e 0 21
e 1 36
e 2 20
e 3 00
e 4 FF
e 6 FF
e 7 03
e 7 02
e 7 01
e 0 00
e 0 11
e 3 33
e 1 33
e 2 33
